//--- include/lce_defines.svh
// Widths, queue depth and credit count shared by the LCE miss-path RTL and its testbench
`ifndef LCE_DEFINES_SVH
`define LCE_DEFINES_SVH

// Physical address and block geometry
`define LCE_PADDR_W 32
`define LCE_BLOCK_OFFSET_W 6
`define LCE_BLOCK_ADDR_W (`LCE_PADDR_W - `LCE_BLOCK_OFFSET_W)

// Endpoint ids, fill payload and way index
`define LCE_ID_W 4
`define LCE_DATA_W 64
`define LCE_WAY_W 2

// Tag view filler so both command views are LCE_DATA_W wide after the header
`define LCE_CMD_PAD_W (`LCE_DATA_W - `LCE_WAY_W - 2 - `LCE_BLOCK_ADDR_W)

// Full command word: op, dst_id, payload
`define LCE_CMD_W (2 + `LCE_ID_W + `LCE_DATA_W)

// Request queue and network flow control
`define LCE_FIFO_DEPTH 4
`define LCE_CREDITS 2

`endif

//--- hw/lce_pkg.sv
// Request/command encodings and the two-view command word, imported by the LCE blocks and testbench
`default_nettype none

`include "lce_defines.svh"

package lce_pkg;

  typedef enum logic {
    e_req_rd = 1'b0,
    e_req_wr = 1'b1
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_cmd_fill    = 2'd0,
    e_cmd_set_tag = 2'd1,
    e_cmd_inval   = 2'd2,
    e_cmd_rsvd    = 2'd3
  } lce_cmd_op_e;

  typedef enum logic [1:0] {
    e_coh_i = 2'd0,
    e_coh_s = 2'd1,
    e_coh_e = 2'd2,
    e_coh_m = 2'd3
  } lce_coh_state_e;

  // Data fill view
  typedef struct packed {
    lce_cmd_op_e                op;
    logic [`LCE_ID_W-1:0]       dst_id;
    logic [`LCE_DATA_W-1:0]     data;
  } lce_cmd_fill_s;

  // Tag/state write view, same header position as the fill view
  typedef struct packed {
    lce_cmd_op_e                op;
    logic [`LCE_ID_W-1:0]       dst_id;
    logic [`LCE_WAY_W-1:0]      way;
    lce_coh_state_e             state;
    logic [`LCE_BLOCK_ADDR_W-1:0] ptag;
    logic [`LCE_CMD_PAD_W-1:0]  pad;
  } lce_cmd_tag_s;

  typedef union packed {
    lce_cmd_fill_s fill;
    lce_cmd_tag_s  tag;
  } lce_cmd_u;

endpackage

`default_nettype wire

//--- hw/cache_miss_encoder.sv
// Captures I$ and D$ misses, holds one pending miss per cache and issues requests round robin
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module cache_miss_encoder (
  input  wire                           clk_i
  , input  wire                         arst_n_i

  , input  wire                         icache_miss_v_i
  , input  wire [`LCE_PADDR_W-1:0]      icache_miss_addr_i
  , output logic                        icache_miss_ready_o

  , input  wire                         dcache_miss_v_i
  , input  wire [`LCE_PADDR_W-1:0]      dcache_miss_addr_i
  , input  wire                         dcache_miss_wr_i
  , output logic                        dcache_miss_ready_o

  , input  wire [`LCE_ID_W-1:0]         icache_lce_id_i
  , input  wire [`LCE_ID_W-1:0]         dcache_lce_id_i

  , input  wire                         icache_fill_done_i
  , input  wire                         dcache_fill_done_i

  , output logic                        q_v_o
  , output logic [`LCE_ID_W-1:0]        q_id_o
  , output lce_pkg::lce_req_type_e      q_type_o
  , output logic [`LCE_BLOCK_ADDR_W-1:0] q_addr_o
  , input  wire                         q_ready_i
);

  import lce_pkg::*;

  logic icache_pend_q, dcache_pend_q;
  logic icache_iss_q, dcache_iss_q;
  logic [`LCE_BLOCK_ADDR_W-1:0] icache_addr_q, dcache_addr_q;
  lce_req_type_e dcache_type_q;
  logic rr_q;
  logic icache_want, dcache_want, sel_d, q_fire;
  logic icache_take, dcache_take;

  assign icache_miss_ready_o = ~icache_pend_q;
  assign dcache_miss_ready_o = ~dcache_pend_q;

  assign icache_take = icache_miss_v_i & icache_miss_ready_o;
  assign dcache_take = dcache_miss_v_i & dcache_miss_ready_o;

  // Captured but not yet handed to the queue
  assign icache_want = icache_pend_q & ~icache_iss_q;
  assign dcache_want = dcache_pend_q & ~dcache_iss_q;

  // rr_q high gives the D$ priority on a tie
  assign sel_d  = dcache_want & (~icache_want | rr_q);
  assign q_v_o  = icache_want | dcache_want;
  assign q_fire = q_v_o & q_ready_i;

  assign q_id_o   = sel_d ? dcache_lce_id_i : icache_lce_id_i;
  assign q_type_o = sel_d ? dcache_type_q : e_req_rd;
  assign q_addr_o = sel_d ? dcache_addr_q : icache_addr_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      icache_pend_q <= 1'b0;
      dcache_pend_q <= 1'b0;
      icache_iss_q  <= 1'b0;
      dcache_iss_q  <= 1'b0;
      rr_q          <= 1'b0;
    end else begin
      if (icache_take) begin
        icache_pend_q <= 1'b1;
        icache_iss_q  <= 1'b0;
      end else if (icache_fill_done_i) begin
        icache_pend_q <= 1'b0;
      end
      if (dcache_take) begin
        dcache_pend_q <= 1'b1;
        dcache_iss_q  <= 1'b0;
      end else if (dcache_fill_done_i) begin
        dcache_pend_q <= 1'b0;
      end
      if (q_fire) begin
        if (sel_d) begin
          dcache_iss_q <= 1'b1;
        end else begin
          icache_iss_q <= 1'b1;
        end
        rr_q <= ~sel_d;
      end
    end
  end

  // Block address and type of the pending miss
  always_ff @(posedge clk_i) begin
    if (icache_take) begin
      icache_addr_q <= icache_miss_addr_i[`LCE_PADDR_W-1:`LCE_BLOCK_OFFSET_W];
    end
    if (dcache_take) begin
      dcache_addr_q <= dcache_miss_addr_i[`LCE_PADDR_W-1:`LCE_BLOCK_OFFSET_W];
      dcache_type_q <= dcache_miss_wr_i ? e_req_wr : e_req_rd;
    end
  end

  // Fills come back from the decoder only for a miss that is still open
  a_fill_has_miss : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (icache_fill_done_i |-> icache_pend_q) and (dcache_fill_done_i |-> dcache_pend_q));

endmodule

`default_nettype wire

//--- hw/lce_req_fifo.sv
// Circular request queue between the miss encoder and the credit sender
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module lce_req_fifo (
  input  wire                           clk_i
  , input  wire                         arst_n_i

  , input  wire                         push_v_i
  , input  wire [`LCE_ID_W-1:0]         push_id_i
  , input  lce_pkg::lce_req_type_e      push_type_i
  , input  wire [`LCE_BLOCK_ADDR_W-1:0] push_addr_i
  , output logic                        push_ready_o

  , output logic                        head_v_o
  , output logic [`LCE_ID_W-1:0]        head_id_o
  , output lce_pkg::lce_req_type_e      head_type_o
  , output logic [`LCE_BLOCK_ADDR_W-1:0] head_addr_o
  , input  wire                         pop_i
);

  import lce_pkg::*;

  localparam int unsigned depth_lp = `LCE_FIFO_DEPTH;
  localparam int unsigned ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int unsigned cnt_w_lp = $clog2(depth_lp + 1);

  logic [`LCE_ID_W-1:0]         id_mem   [depth_lp];
  lce_req_type_e                type_mem [depth_lp];
  logic [`LCE_BLOCK_ADDR_W-1:0] addr_mem [depth_lp];

  logic [ptr_w_lp-1:0] rptr_q, wptr_q;
  logic [cnt_w_lp-1:0] count_q;
  logic push, pop;

  assign push_ready_o = (count_q != cnt_w_lp'(depth_lp));
  assign head_v_o     = (count_q != '0);
  assign push         = push_v_i & push_ready_o;
  assign pop          = pop_i & head_v_o;

  assign head_id_o   = id_mem[rptr_q];
  assign head_type_o = type_mem[rptr_q];
  assign head_addr_o = addr_mem[rptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == ptr_w_lp'(depth_lp - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == ptr_w_lp'(depth_lp - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wptr_q]   <= push_id_i;
      type_mem[wptr_q] <= push_type_i;
      addr_mem[wptr_q] <= push_addr_i;
    end
  end

  // Encoder keeps at most one entry per cache, so a push never meets a full queue
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_v_i |-> push_ready_o);

  // Sender pops only a valid head
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> head_v_o);

endmodule

`default_nettype wire

//--- hw/lce_credit_sender.sv
// Drives the outgoing LCE request channel from the queue head under a network credit limit
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module lce_credit_sender (
  input  wire                           clk_i
  , input  wire                         arst_n_i

  , input  wire                         head_v_i
  , input  wire [`LCE_ID_W-1:0]         head_id_i
  , input  lce_pkg::lce_req_type_e      head_type_i
  , input  wire [`LCE_BLOCK_ADDR_W-1:0] head_addr_i
  , output logic                        head_pop_o

  , output logic                        lce_req_v_o
  , output logic [`LCE_ID_W-1:0]        lce_req_id_o
  , output lce_pkg::lce_req_type_e      lce_req_type_o
  , output logic [`LCE_BLOCK_ADDR_W-1:0] lce_req_addr_o
  , input  wire                         lce_req_ready_i

  , input  wire                         lce_credit_return_i
  , output logic                        credits_empty_o
);

  localparam int unsigned credits_lp = `LCE_CREDITS;
  localparam int unsigned cnt_w_lp   = $clog2(credits_lp + 1);

  logic [cnt_w_lp-1:0] credit_cnt_q;
  logic send;

  assign credits_empty_o = (credit_cnt_q == '0);

  // Head is offered to the network only while a credit is free
  assign lce_req_v_o    = head_v_i & ~credits_empty_o;
  assign lce_req_id_o   = head_id_i;
  assign lce_req_type_o = head_type_i;
  assign lce_req_addr_o = head_addr_i;

  assign send       = lce_req_v_o & lce_req_ready_i;
  assign head_pop_o = send;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_cnt_q <= cnt_w_lp'(credits_lp);
    end else begin
      case ({send, lce_credit_return_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_cnt_q <= cnt_w_lp'(credits_lp));

  // Network returns only credits it was given
  a_no_extra_return : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lce_credit_return_i |-> (credit_cnt_q != cnt_w_lp'(credits_lp)));

endmodule

`default_nettype wire

//--- hw/lce_cmd_decoder.sv
// Consumes coherence commands and routes fills and tag writes to the addressed cache
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module lce_cmd_decoder (
  input  wire                           clk_i
  , input  wire                         arst_n_i

  , input  lce_pkg::lce_cmd_u           lce_cmd_i
  , input  wire                         lce_cmd_v_i
  , output logic                        lce_cmd_yumi_o

  , input  wire [`LCE_ID_W-1:0]         icache_lce_id_i
  , input  wire [`LCE_ID_W-1:0]         dcache_lce_id_i

  , output logic                        icache_data_v_o
  , output logic                        dcache_data_v_o
  , output logic [`LCE_DATA_W-1:0]      data_o

  , output logic                        icache_tag_v_o
  , output logic                        dcache_tag_v_o
  , output logic [`LCE_WAY_W-1:0]       tag_way_o
  , output lce_pkg::lce_coh_state_e     tag_state_o
  , output logic [`LCE_BLOCK_ADDR_W-1:0] tag_ptag_o

  , output logic                        icache_fill_done_o
  , output logic                        dcache_fill_done_o
);

  import lce_pkg::*;

  lce_cmd_op_e op;
  logic hit_i, hit_d;
  logic is_fill, is_tag;
  logic icache_data_v_q, dcache_data_v_q;
  logic icache_tag_v_q, dcache_tag_v_q;
  logic [`LCE_DATA_W-1:0] data_q;
  logic [`LCE_WAY_W-1:0] way_q;
  lce_coh_state_e state_q;
  logic [`LCE_BLOCK_ADDR_W-1:0] ptag_q;

  // One command per cycle, never stalled
  assign lce_cmd_yumi_o = lce_cmd_v_i;

  // op and dst_id sit at the same place in both views
  assign op    = lce_cmd_i.fill.op;
  assign hit_i = (lce_cmd_i.fill.dst_id == icache_lce_id_i);
  assign hit_d = (lce_cmd_i.fill.dst_id == dcache_lce_id_i);

  assign is_fill = lce_cmd_v_i & (op == e_cmd_fill);
  assign is_tag  = lce_cmd_v_i & ((op == e_cmd_set_tag) | (op == e_cmd_inval));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      icache_data_v_q <= 1'b0;
      dcache_data_v_q <= 1'b0;
      icache_tag_v_q  <= 1'b0;
      dcache_tag_v_q  <= 1'b0;
    end else begin
      icache_data_v_q <= is_fill & hit_i;
      dcache_data_v_q <= is_fill & hit_d;
      icache_tag_v_q  <= is_tag & hit_i;
      dcache_tag_v_q  <= is_tag & hit_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_fill) begin
      data_q <= lce_cmd_i.fill.data;
    end
    if (is_tag) begin
      way_q   <= lce_cmd_i.tag.way;
      ptag_q  <= lce_cmd_i.tag.ptag;
      // Invalidate ignores the state field
      state_q <= (op == e_cmd_inval) ? e_coh_i : lce_cmd_i.tag.state;
    end
  end

  assign icache_data_v_o = icache_data_v_q;
  assign dcache_data_v_o = dcache_data_v_q;
  assign data_o          = data_q;

  assign icache_tag_v_o = icache_tag_v_q;
  assign dcache_tag_v_o = dcache_tag_v_q;
  assign tag_way_o      = way_q;
  assign tag_state_o    = state_q;
  assign tag_ptag_o     = ptag_q;

  // Fill completes the miss in the same cycle its data is delivered
  assign icache_fill_done_o = icache_data_v_q;
  assign dcache_fill_done_o = dcache_data_v_q;

endmodule

`default_nettype wire

//--- hw/core_lce_top.sv
// Top of the I$/D$ coherence endpoint pair: miss encoder, request queue, credit sender, decoder
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module core_lce_top (
  input  wire                           clk_i
  , input  wire                         arst_n_i

  , input  wire                         icache_miss_v_i
  , input  wire [`LCE_PADDR_W-1:0]      icache_miss_addr_i
  , output logic                        icache_miss_ready_o
  , input  wire                         dcache_miss_v_i
  , input  wire [`LCE_PADDR_W-1:0]      dcache_miss_addr_i
  , input  wire                         dcache_miss_wr_i
  , output logic                        dcache_miss_ready_o

  , input  wire [`LCE_ID_W-1:0]         icache_lce_id_i
  , input  wire [`LCE_ID_W-1:0]         dcache_lce_id_i

  // LCE request channel
  , output logic                        lce_req_v_o
  , output logic [`LCE_ID_W-1:0]        lce_req_id_o
  , output lce_pkg::lce_req_type_e      lce_req_type_o
  , output logic [`LCE_BLOCK_ADDR_W-1:0] lce_req_addr_o
  , input  wire                         lce_req_ready_i
  , input  wire                         lce_credit_return_i
  , output logic                        credits_empty_o

  // LCE command channel
  , input  lce_pkg::lce_cmd_u           lce_cmd_i
  , input  wire                         lce_cmd_v_i
  , output logic                        lce_cmd_yumi_o

  , output logic                        icache_data_v_o
  , output logic                        dcache_data_v_o
  , output logic [`LCE_DATA_W-1:0]      data_o
  , output logic                        icache_tag_v_o
  , output logic                        dcache_tag_v_o
  , output logic [`LCE_WAY_W-1:0]       tag_way_o
  , output lce_pkg::lce_coh_state_e     tag_state_o
  , output logic [`LCE_BLOCK_ADDR_W-1:0] tag_ptag_o
);

  import lce_pkg::*;

  logic q_v, q_ready;
  logic [`LCE_ID_W-1:0] q_id;
  lce_req_type_e q_type;
  logic [`LCE_BLOCK_ADDR_W-1:0] q_addr;

  logic head_v, head_pop;
  logic [`LCE_ID_W-1:0] head_id;
  lce_req_type_e head_type;
  logic [`LCE_BLOCK_ADDR_W-1:0] head_addr;

  logic icache_fill_done, dcache_fill_done;

  cache_miss_encoder miss_enc (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.icache_miss_v_i(icache_miss_v_i)
    ,.icache_miss_addr_i(icache_miss_addr_i)
    ,.icache_miss_ready_o(icache_miss_ready_o)
    ,.dcache_miss_v_i(dcache_miss_v_i)
    ,.dcache_miss_addr_i(dcache_miss_addr_i)
    ,.dcache_miss_wr_i(dcache_miss_wr_i)
    ,.dcache_miss_ready_o(dcache_miss_ready_o)
    ,.icache_lce_id_i(icache_lce_id_i)
    ,.dcache_lce_id_i(dcache_lce_id_i)
    ,.icache_fill_done_i(icache_fill_done)
    ,.dcache_fill_done_i(dcache_fill_done)
    ,.q_v_o(q_v)
    ,.q_id_o(q_id)
    ,.q_type_o(q_type)
    ,.q_addr_o(q_addr)
    ,.q_ready_i(q_ready)
  );

  lce_req_fifo req_fifo (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.push_v_i(q_v)
    ,.push_id_i(q_id)
    ,.push_type_i(q_type)
    ,.push_addr_i(q_addr)
    ,.push_ready_o(q_ready)
    ,.head_v_o(head_v)
    ,.head_id_o(head_id)
    ,.head_type_o(head_type)
    ,.head_addr_o(head_addr)
    ,.pop_i(head_pop)
  );

  lce_credit_sender req_send (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.head_v_i(head_v)
    ,.head_id_i(head_id)
    ,.head_type_i(head_type)
    ,.head_addr_i(head_addr)
    ,.head_pop_o(head_pop)
    ,.lce_req_v_o(lce_req_v_o)
    ,.lce_req_id_o(lce_req_id_o)
    ,.lce_req_type_o(lce_req_type_o)
    ,.lce_req_addr_o(lce_req_addr_o)
    ,.lce_req_ready_i(lce_req_ready_i)
    ,.lce_credit_return_i(lce_credit_return_i)
    ,.credits_empty_o(credits_empty_o)
  );

  lce_cmd_decoder cmd_dec (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.lce_cmd_i(lce_cmd_i)
    ,.lce_cmd_v_i(lce_cmd_v_i)
    ,.lce_cmd_yumi_o(lce_cmd_yumi_o)
    ,.icache_lce_id_i(icache_lce_id_i)
    ,.dcache_lce_id_i(dcache_lce_id_i)
    ,.icache_data_v_o(icache_data_v_o)
    ,.dcache_data_v_o(dcache_data_v_o)
    ,.data_o(data_o)
    ,.icache_tag_v_o(icache_tag_v_o)
    ,.dcache_tag_v_o(dcache_tag_v_o)
    ,.tag_way_o(tag_way_o)
    ,.tag_state_o(tag_state_o)
    ,.tag_ptag_o(tag_ptag_o)
    ,.icache_fill_done_o(icache_fill_done)
    ,.dcache_fill_done_o(dcache_fill_done)
  );

endmodule

`default_nettype wire

//--- testbench/tb_core_lce_top.sv
// Testbench for core_lce_top: drives misses and commands, checks requests and routed strobes
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module tb_core_lce_top;

  import lce_pkg::*;

  localparam logic [`LCE_ID_W-1:0] icache_id_lp  = 4'h0;
  localparam logic [`LCE_ID_W-1:0] dcache_id_lp  = 4'h1;
  localparam logic [`LCE_ID_W-1:0] unknown_id_lp = 4'h5;
  localparam int num_steps_lp   = 9;
  localparam int cycle_limit_lp = 40 * num_steps_lp;

  typedef struct packed {
    logic [`LCE_ID_W-1:0]         id;
    lce_req_type_e                rtype;
    logic [`LCE_BLOCK_ADDR_W-1:0] addr;
  } req_t;

  typedef struct packed {
    logic                         routed;
    logic                         is_fill;
    logic                         cache;
    logic [`LCE_DATA_W-1:0]       data;
    logic [`LCE_WAY_W-1:0]        way;
    lce_coh_state_e               state;
    logic [`LCE_BLOCK_ADDR_W-1:0] ptag;
  } route_t;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic icache_miss_v_i, dcache_miss_v_i, dcache_miss_wr_i;
  logic [`LCE_PADDR_W-1:0] icache_miss_addr_i, dcache_miss_addr_i;
  logic icache_miss_ready_o, dcache_miss_ready_o;
  logic [`LCE_ID_W-1:0] icache_lce_id_i, dcache_lce_id_i;
  logic lce_req_v_o, lce_req_ready_i, lce_credit_return_i, credits_empty_o;
  logic [`LCE_ID_W-1:0] lce_req_id_o;
  lce_req_type_e lce_req_type_o;
  logic [`LCE_BLOCK_ADDR_W-1:0] lce_req_addr_o;
  lce_cmd_u lce_cmd_i;
  logic lce_cmd_v_i, lce_cmd_yumi_o;
  logic icache_data_v_o, dcache_data_v_o, icache_tag_v_o, dcache_tag_v_o;
  logic [`LCE_DATA_W-1:0] data_o;
  logic [`LCE_WAY_W-1:0] tag_way_o;
  lce_coh_state_e tag_state_o;
  logic [`LCE_BLOCK_ADDR_W-1:0] tag_ptag_o;

  logic [31:0] lfsr_q = 32'h7b08cbcf;
  req_t   exp_req[$];
  route_t exp_cmd[$];
  int mismatch_cnt = 0;
  int other_cnt = 0;
  int sends = 0;
  int credits_out = 0;
  int cycle_cnt = 0;

  core_lce_top uut (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.icache_miss_v_i(icache_miss_v_i)
    ,.icache_miss_addr_i(icache_miss_addr_i)
    ,.icache_miss_ready_o(icache_miss_ready_o)
    ,.dcache_miss_v_i(dcache_miss_v_i)
    ,.dcache_miss_addr_i(dcache_miss_addr_i)
    ,.dcache_miss_wr_i(dcache_miss_wr_i)
    ,.dcache_miss_ready_o(dcache_miss_ready_o)
    ,.icache_lce_id_i(icache_lce_id_i)
    ,.dcache_lce_id_i(dcache_lce_id_i)
    ,.lce_req_v_o(lce_req_v_o)
    ,.lce_req_id_o(lce_req_id_o)
    ,.lce_req_type_o(lce_req_type_o)
    ,.lce_req_addr_o(lce_req_addr_o)
    ,.lce_req_ready_i(lce_req_ready_i)
    ,.lce_credit_return_i(lce_credit_return_i)
    ,.credits_empty_o(credits_empty_o)
    ,.lce_cmd_i(lce_cmd_i)
    ,.lce_cmd_v_i(lce_cmd_v_i)
    ,.lce_cmd_yumi_o(lce_cmd_yumi_o)
    ,.icache_data_v_o(icache_data_v_o)
    ,.dcache_data_v_o(dcache_data_v_o)
    ,.data_o(data_o)
    ,.icache_tag_v_o(icache_tag_v_o)
    ,.dcache_tag_v_o(dcache_tag_v_o)
    ,.tag_way_o(tag_way_o)
    ,.tag_state_o(tag_state_o)
    ,.tag_ptag_o(tag_ptag_o)
  );

  always #5 clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [`LCE_PADDR_W-1:0] rand_addr();
    logic [63:0] v;
    v = rand_bits(`LCE_PADDR_W);
    return v[`LCE_PADDR_W-1:0];
  endfunction

  function automatic lce_cmd_u make_fill(input logic [`LCE_ID_W-1:0] dst,
                                         input logic [`LCE_DATA_W-1:0] data);
    lce_cmd_u c;
    c = '0;
    c.fill.op     = e_cmd_fill;
    c.fill.dst_id = dst;
    c.fill.data   = data;
    return c;
  endfunction

  function automatic lce_cmd_u random_tag(input lce_cmd_op_e op,
                                          input logic [`LCE_ID_W-1:0] dst);
    lce_cmd_u c;
    logic [63:0] v;
    c = '0;
    v = rand_bits(30);
    c.tag.op     = op;
    c.tag.dst_id = dst;
    c.tag.way    = v[29:28];
    c.tag.state  = lce_coh_state_e'(v[27:26]);
    // Nonzero state so an invalidate has to force e_coh_i
    if (c.tag.state == e_coh_i) begin
      c.tag.state = e_coh_m;
    end
    c.tag.ptag   = v[25:0];
    return c;
  endfunction

  // Reference model of a miss and of a command's routing
  function automatic req_t expected_request(input logic dcache,
                                            input logic [`LCE_PADDR_W-1:0] addr,
                                            input logic wr);
    req_t r;
    r.id    = dcache ? dcache_id_lp : icache_id_lp;
    r.rtype = (dcache && wr) ? e_req_wr : e_req_rd;
    r.addr  = addr[`LCE_PADDR_W-1:`LCE_BLOCK_OFFSET_W];
    return r;
  endfunction

  function automatic route_t expected_route(input lce_cmd_u cmd);
    route_t r;
    r = '0;
    if (cmd.fill.dst_id == icache_id_lp) begin
      r.routed = 1'b1;
    end else if (cmd.fill.dst_id == dcache_id_lp) begin
      r.routed = 1'b1;
      r.cache  = 1'b1;
    end
    case (cmd.fill.op)
      e_cmd_fill: begin
        r.is_fill = 1'b1;
        r.data    = cmd.fill.data;
      end
      e_cmd_set_tag, e_cmd_inval: begin
        r.way   = cmd.tag.way;
        r.ptag  = cmd.tag.ptag;
        r.state = (cmd.tag.op == e_cmd_inval) ? e_coh_i : cmd.tag.state;
      end
      default: r.routed = 1'b0;
    endcase
    return r;
  endfunction

  task automatic check_req(input req_t exp, input logic [`LCE_ID_W-1:0] id,
                           input lce_req_type_e rtype,
                           input logic [`LCE_BLOCK_ADDR_W-1:0] addr);
    if (id !== exp.id || rtype !== exp.rtype || addr !== exp.addr) begin
      mismatch_cnt++;
      $display("mismatch at %0t: request id %0h type %0d addr %h, expected %0h %0d %h",
               $time, id, rtype, addr, exp.id, exp.rtype, exp.addr);
    end
  endtask

  task automatic check_fill(input logic exp_cache, input logic [`LCE_DATA_W-1:0] exp_data,
                            input logic cache, input logic [`LCE_DATA_W-1:0] data);
    if (cache !== exp_cache || data !== exp_data) begin
      mismatch_cnt++;
      $display("mismatch at %0t: fill to cache %0d data %h, expected cache %0d data %h",
               $time, cache, data, exp_cache, exp_data);
    end
  endtask

  task automatic check_tag(input route_t exp, input logic cache,
                           input logic [`LCE_WAY_W-1:0] way, input lce_coh_state_e state,
                           input logic [`LCE_BLOCK_ADDR_W-1:0] ptag);
    if (cache !== exp.cache || way !== exp.way || state !== exp.state || ptag !== exp.ptag) begin
      mismatch_cnt++;
      $display("mismatch at %0t: tag to cache %0d way %0d state %0d ptag %h, expected %0d %0d %0d %h",
               $time, cache, way, state, ptag, exp.cache, exp.way, exp.state, exp.ptag);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic handle_request();
    int idx;
    idx = -1;
    for (int k = 0; k < exp_req.size(); k++) begin
      if (exp_req[k].id == lce_req_id_o) begin
        idx = k;
      end
    end
    if (idx < 0) begin
      other_cnt++;
      $display("error at %0t: request from id %0h was not expected", $time, lce_req_id_o);
    end else begin
      check_req(exp_req[idx], lce_req_id_o, lce_req_type_o, lce_req_addr_o);
      exp_req.delete(idx);
    end
  endtask

  task automatic handle_strobe();
    route_t e;
    logic cache;
    cache = dcache_data_v_o | dcache_tag_v_o;
    if ((icache_data_v_o + dcache_data_v_o + icache_tag_v_o + dcache_tag_v_o) > 1) begin
      other_cnt++;
      $display("error at %0t: more than one cache strobe in one cycle", $time);
    end else if (exp_cmd.size() == 0) begin
      other_cnt++;
      $display("error at %0t: cache strobe without a routed command", $time);
    end else begin
      e = exp_cmd.pop_front();
      if (e.is_fill != (icache_data_v_o | dcache_data_v_o)) begin
        mismatch_cnt++;
        $display("mismatch at %0t: strobe kind fill=%0d, expected fill=%0d",
                 $time, ~e.is_fill, e.is_fill);
      end else if (e.is_fill) begin
        check_fill(e.cache, e.data, cache, data_o);
      end else begin
        check_tag(e, cache, tag_way_o, tag_state_o, tag_ptag_o);
      end
    end
  endtask

  // Monitor samples mid-cycle, when all inputs and outputs are settled
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (lce_req_v_o && lce_req_ready_i) begin
        handle_request();
        sends++;
        credits_out++;
      end
      if (lce_credit_return_i) begin
        credits_out--;
      end
      if (icache_data_v_o || dcache_data_v_o || icache_tag_v_o || dcache_tag_v_o) begin
        handle_strobe();
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit_lp) begin
      $display("error: run went past %0d cycles without finishing", cycle_limit_lp);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic issue_misses(input logic do_i, input logic do_d,
                              input logic [`LCE_PADDR_W-1:0] iaddr,
                              input logic [`LCE_PADDR_W-1:0] daddr, input logic dwr);
    @(negedge clk_i);
    while ((do_i && !icache_miss_ready_o) || (do_d && !dcache_miss_ready_o)) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    icache_miss_v_i    <= do_i;
    icache_miss_addr_i <= iaddr;
    dcache_miss_v_i    <= do_d;
    dcache_miss_addr_i <= daddr;
    dcache_miss_wr_i   <= dwr;
    if (do_i) begin
      exp_req.push_back(expected_request(1'b0, iaddr, 1'b0));
    end
    if (do_d) begin
      exp_req.push_back(expected_request(1'b1, daddr, dwr));
    end
    @(posedge clk_i);
    icache_miss_v_i <= 1'b0;
    dcache_miss_v_i <= 1'b0;
  endtask

  // D$ miss strobe while one is pending must be refused
  task automatic try_refused_dmiss(input logic [`LCE_PADDR_W-1:0] addr);
    @(posedge clk_i);
    dcache_miss_v_i    <= 1'b1;
    dcache_miss_addr_i <= addr;
    dcache_miss_wr_i   <= 1'b0;
    @(negedge clk_i);
    check_flag("dcache_miss_ready_o", 1'b0, dcache_miss_ready_o);
    @(posedge clk_i);
    dcache_miss_v_i <= 1'b0;
  endtask

  task automatic send_cmd(input lce_cmd_u cmd);
    route_t r;
    r = expected_route(cmd);
    @(posedge clk_i);
    if (r.routed) begin
      exp_cmd.push_back(r);
    end
    lce_cmd_i   <= cmd;
    lce_cmd_v_i <= 1'b1;
    @(negedge clk_i);
    check_flag("lce_cmd_yumi_o", 1'b1, lce_cmd_yumi_o);
    @(posedge clk_i);
    lce_cmd_v_i <= 1'b0;
  endtask

  task automatic fill_and_release(input logic dcache);
    send_cmd(make_fill(dcache ? dcache_id_lp : icache_id_lp, rand_bits(`LCE_DATA_W)));
    @(negedge clk_i);
    check_flag("miss_ready_o one cycle after fill", 1'b0,
               dcache ? dcache_miss_ready_o : icache_miss_ready_o);
    @(negedge clk_i);
    check_flag("miss_ready_o two cycles after fill", 1'b1,
               dcache ? dcache_miss_ready_o : icache_miss_ready_o);
  endtask

  task automatic return_credits();
    while (credits_out > 0) begin
      @(posedge clk_i);
      lce_credit_return_i <= 1'b1;
      @(posedge clk_i);
      lce_credit_return_i <= 1'b0;
    end
  endtask

  task automatic expect_held(input int n);
    int start;
    start = sends;
    repeat (n) @(negedge clk_i);
    @(posedge clk_i);
    if (sends != start) begin
      other_cnt++;
      $display("error at %0t: a request left while the channel was blocked", $time);
    end
  endtask

  // Drain expectations, idle so strays show up, then give credits back
  task automatic finish_step();
    while (exp_req.size() != 0 || exp_cmd.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    return_credits();
  endtask

  initial begin
    arst_n_i            = 1'b0;
    icache_miss_v_i     = 1'b0;
    icache_miss_addr_i  = '0;
    dcache_miss_v_i     = 1'b0;
    dcache_miss_addr_i  = '0;
    dcache_miss_wr_i    = 1'b0;
    icache_lce_id_i     = icache_id_lp;
    dcache_lce_id_i     = dcache_id_lp;
    lce_req_ready_i     = 1'b1;
    lce_credit_return_i = 1'b0;
    lce_cmd_i           = '0;
    lce_cmd_v_i         = 1'b0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;

    @(negedge clk_i);
    check_flag("lce_req_v_o", 1'b0, lce_req_v_o);
    check_flag("lce_cmd_yumi_o", 1'b0, lce_cmd_yumi_o);
    check_flag("icache_data_v_o", 1'b0, icache_data_v_o);
    check_flag("dcache_data_v_o", 1'b0, dcache_data_v_o);
    check_flag("icache_tag_v_o", 1'b0, icache_tag_v_o);
    check_flag("dcache_tag_v_o", 1'b0, dcache_tag_v_o);
    check_flag("icache_miss_ready_o", 1'b1, icache_miss_ready_o);
    check_flag("dcache_miss_ready_o", 1'b1, dcache_miss_ready_o);
    check_flag("credits_empty_o", 1'b0, credits_empty_o);

    // I$ miss, then D$ store miss with a refused second miss
    issue_misses(1'b1, 1'b0, rand_addr(), '0, 1'b0);
    finish_step();
    issue_misses(1'b0, 1'b1, '0, rand_addr(), 1'b1);
    finish_step();
    try_refused_dmiss(rand_addr());
    finish_step();

    // Fills release both caches
    fill_and_release(1'b0);
    fill_and_release(1'b1);
    finish_step();

    // Simultaneous misses, either order
    issue_misses(1'b1, 1'b1, rand_addr(), rand_addr(), 1'b0);
    finish_step();
    fill_and_release(1'b1);
    fill_and_release(1'b0);
    finish_step();

    // Tag writes, invalidates and commands that route nowhere
    send_cmd(random_tag(e_cmd_set_tag, icache_id_lp));
    send_cmd(random_tag(e_cmd_set_tag, dcache_id_lp));
    send_cmd(random_tag(e_cmd_inval, dcache_id_lp));
    send_cmd(random_tag(e_cmd_inval, icache_id_lp));
    send_cmd(make_fill(unknown_id_lp, rand_bits(`LCE_DATA_W)));
    send_cmd(random_tag(e_cmd_set_tag, unknown_id_lp));
    send_cmd(random_tag(e_cmd_rsvd, icache_id_lp));
    finish_step();

    // Credits withheld
    issue_misses(1'b1, 1'b1, rand_addr(), rand_addr(), 1'b1);
    while (exp_req.size() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check_flag("credits_empty_o", 1'b1, credits_empty_o);
    send_cmd(make_fill(icache_id_lp, rand_bits(`LCE_DATA_W)));
    issue_misses(1'b1, 1'b0, rand_addr(), '0, 1'b0);
    expect_held(8);
    @(negedge clk_i);
    check_flag("lce_req_v_o", 1'b0, lce_req_v_o);
    @(posedge clk_i);
    lce_req_ready_i     <= 1'b0;
    lce_credit_return_i <= 1'b1;
    @(posedge clk_i);
    lce_credit_return_i <= 1'b0;
    // Returned credit lets the head be offered, and it stays offered while not ready
    repeat (6) begin
      @(negedge clk_i);
      check_flag("lce_req_v_o while not ready", 1'b1, lce_req_v_o);
    end
    @(posedge clk_i);
    lce_req_ready_i <= 1'b1;
    finish_step();
    send_cmd(make_fill(dcache_id_lp, rand_bits(`LCE_DATA_W)));
    send_cmd(make_fill(icache_id_lp, rand_bits(`LCE_DATA_W)));
    finish_step();

    $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- core_lce_top.f
+incdir+include
hw/lce_pkg.sv
hw/cache_miss_encoder.sv
hw/lce_req_fifo.sv
hw/lce_credit_sender.sv
hw/lce_cmd_decoder.sv
hw/core_lce_top.sv
testbench/tb_core_lce_top.sv

//--- Makefile
# Verilator simulation of the LCE miss path

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f core_lce_top.f \
		--top-module tb_core_lce_top -o tb_core_lce_top
	./obj_dir/tb_core_lce_top | awk '{ print } /\*\*\* TEST PASSED \*\*\*/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
